//--- board_ctrl_top.f
+incdir+source
+incdir+verification
source/bus_pkg.sv
source/board_pkg.sv
source/setting_regs.sv
source/sfp_status_monitor.sv
source/readback_mux.sv
source/board_ctrl_top.sv
verification/tb_board_ctrl_top.sv

//--- verification/board_ctrl_model.svh
// Reference model of the board control block
// Mirrors the settings registers, SFP+ sticky flags and readback words

`ifndef BOARD_CTRL_MODEL_SVH
`define BOARD_CTRL_MODEL_SVH

settings_t   exp_set;
sfp_pins_t   exp_pins [2];
sfp_pins_t   exp_chg [2];
logic [15:0] exp_phy [2];
logic [7:0]  exp_clk_status;

// GPSDO on, 10 MHz reference, everything else zero
function automatic void reset_model();
   exp_set               = '0;
   exp_set.clock_control = 8'h40;
   exp_set.ref_freq      = 32'd10_000_000;
   exp_chg[0]            = '0;
   exp_chg[1]            = '0;
endfunction

function automatic void apply_write(input logic [7:0] addr, input logic [31:0] data);
   case (addr)
      `BC_SR_LEDS:        exp_set.leds          = data[1:0];
      `BC_SR_SW_RST:      exp_set.sw_rst        = data[3:0];
      `BC_SR_CLOCK_CTRL:  exp_set.clock_control = data[7:0];
      `BC_SR_DEVICE_ID:   exp_set.device_id     = data[15:0];
      `BC_SR_REF_FREQ:    exp_set.ref_freq      = data;
      `BC_SR_SFPP_CTRL0:  exp_set.sfpp_ctrl0    = data[1:0];
      `BC_SR_SFPP_CTRL1:  exp_set.sfpp_ctrl1    = data[1:0];
      `BC_SR_FP_GPIO_SRC: exp_set.fp_gpio_src   = data[23:0];
      default: ;
   endcase
endfunction

// Any pin that differs from its last value leaves a sticky flag
function automatic void apply_cage_inputs(input int c, input sfp_pins_t pins,
                                          input logic [15:0] phy);
   exp_chg[c]  = exp_chg[c] | (exp_pins[c] ^ pins);
   exp_pins[c] = pins;
   exp_phy[c]  = phy;
endfunction

// Counter is checked by difference in the testbench, not here
function automatic logic [31:0] expected_readback(input logic [7:0] addr);
   logic [31:0] word;
   int          c;
   word = '0;
   c    = (addr == `BC_RB_SFPP_STATUS1) ? 1 : 0;
   case (addr)
      `BC_RB_CLK_STATUS:   word = {24'h0, exp_clk_status};
      `BC_RB_COMPAT_NUM:   word = 32'h0027_0000;
      `BC_RB_SFPP_STATUS0, `BC_RB_SFPP_STATUS1: begin
         word       = {exp_phy[c], 10'h0, exp_chg[c], exp_pins[c]};
         exp_chg[c] = '0;
      end
      `BC_RB_LEDS:         word = {30'h0, exp_set.leds};
      `BC_RB_SW_RST:       word = {28'h0, exp_set.sw_rst};
      `BC_RB_CLOCK_CTRL:   word = {24'h0, exp_set.clock_control};
      `BC_RB_DEVICE_ID:    word = {16'h0, exp_set.device_id};
      `BC_RB_REF_FREQ:     word = exp_set.ref_freq;
      `BC_RB_SFPP_CTRL:    word = {28'h0, exp_set.sfpp_ctrl1, exp_set.sfpp_ctrl0};
      `BC_RB_FP_GPIO_SRC:  word = {8'h0, exp_set.fp_gpio_src};
      default:             word = '0;
   endcase
   return word;
endfunction

`endif

//--- verification/tb_board_ctrl_top.sv
// Testbench for the board control register block
// Seeded random writes and reads, counter spacing and SFP+ pin
// activity, all checked against the reference model

`timescale 1ns/10ps

`include "board_ctrl_settings.svh"

module tb_board_ctrl_top;

   import bus_pkg::*;
   import board_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int N_WRITES   = 64;
   localparam int N_COUNTER  = 16;
   localparam int K_MAX      = 32;
   localparam int N_PINS     = 16;
   localparam int N_CLEAR    = 8;
   localparam int N_FIXED    = 8;
   // Worst-case cycles of every test added up
   localparam int STIM_CYCLES = 24 + N_WRITES * 4 + N_COUNTER * (K_MAX + 2) +
                                N_PINS * 8 + N_CLEAR * 9 + N_FIXED * 2;

   logic        clk;
   logic        i_rst_n;
   bus_req_t    i_req;
   logic [7:0]  i_clock_status;
   sfp_pins_t   i_sfp0_pins;
   sfp_pins_t   i_sfp1_pins;
   logic [15:0] i_sfp0_phy_status;
   logic [15:0] i_sfp1_phy_status;
   rb_rsp_t     o_rsp;
   settings_t   o_settings;
   logic        o_ref_freq_changed;

   string       cur_test;
   int          test_errs;
   int          total_errs;
   int          tests_run;
   int          tests_failed;

   logic [7:0] wr_addrs [8] = '{`BC_SR_LEDS, `BC_SR_SW_RST, `BC_SR_CLOCK_CTRL,
      `BC_SR_DEVICE_ID, `BC_SR_REF_FREQ, `BC_SR_SFPP_CTRL0, `BC_SR_SFPP_CTRL1,
      `BC_SR_FP_GPIO_SRC};
   logic [7:0] rb_addrs [7] = '{`BC_RB_LEDS, `BC_RB_SW_RST, `BC_RB_CLOCK_CTRL,
      `BC_RB_DEVICE_ID, `BC_RB_REF_FREQ, `BC_RB_SFPP_CTRL, `BC_RB_FP_GPIO_SRC};

   `include "board_ctrl_model.svh"

   board_ctrl_top dut0 (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_req              (i_req),
      .i_clock_status     (i_clock_status),
      .i_sfp0_pins        (i_sfp0_pins),
      .i_sfp1_pins        (i_sfp1_pins),
      .i_sfp0_phy_status  (i_sfp0_phy_status),
      .i_sfp1_phy_status  (i_sfp1_phy_status),
      .o_rsp              (o_rsp),
      .o_settings         (o_settings),
      .o_ref_freq_changed (o_ref_freq_changed)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // ------------------------------
   // Check helpers
   // ------------------------------
   task automatic record_failure();
      test_errs++;
      total_errs++;
   endtask

   task automatic check_value(input logic [95:0] exp, input logic [95:0] act);
      assert (act === exp) else begin
         $display("ERR %s expected 0x%0h actual 0x%0h", cur_test, exp, act);
         record_failure();
      end
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("%s: PASS", cur_test);
      end else begin
         tests_failed++;
         $display("%s: FAIL, %0d errors", cur_test, test_errs);
      end
   endtask

   // ------------------------------
   // Bus tasks entered and left on a falling edge
   // ------------------------------
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         assert (!o_rsp.valid && !o_ref_freq_changed) else begin
            $display("%s: response or reference pulse high with no request", cur_test);
            record_failure();
         end
      end
   endtask

   task automatic issue_write(input logic [7:0] addr, input logic [31:0] data);
      i_req = '{op: BUS_WRITE, addr: addr, data: data};
      @(negedge clk);
      i_req = '{op: BUS_IDLE, addr: '0, data: '0};
      apply_write(addr, data);
      assert (o_rsp.valid === 1'b0) else begin
         $display("%s: response valid after a write to address %0d", cur_test, addr);
         record_failure();
      end
      // Pulse only in the cycle after a reference frequency write
      check_value(96'(addr == `BC_SR_REF_FREQ), 96'(o_ref_freq_changed));
      check_value(96'(exp_set), 96'(o_settings));
   endtask

   task automatic issue_read(input logic [7:0] addr, output logic [31:0] data);
      i_req = '{op: BUS_READ, addr: addr, data: $urandom()};
      @(negedge clk);
      i_req = '{op: BUS_IDLE, addr: '0, data: '0};
      assert (o_rsp.valid === 1'b1) else begin
         $display("%s: no response in the cycle after the read of address %0d",
                  cur_test, addr);
         record_failure();
      end
      assert (o_ref_freq_changed === 1'b0) else begin
         $display("%s: reference pulse high after the read of address %0d",
                  cur_test, addr);
         record_failure();
      end
      data = o_rsp.data;
   endtask

   task automatic read_and_check(input logic [7:0] addr);
      logic [31:0] data;
      logic [31:0] exp;
      issue_read(addr, data);
      exp = expected_readback(addr);
      check_value(96'(exp), 96'(data));
   endtask

   // Drives new pins and PHY status on both cages and waits for them to settle
   task automatic change_cages(input sfp_pins_t p0, input sfp_pins_t p1);
      logic [15:0] phy0;
      logic [15:0] phy1;
      phy0              = $urandom();
      phy1              = $urandom();
      i_sfp0_pins       = p0;
      i_sfp1_pins       = p1;
      i_sfp0_phy_status = phy0;
      i_sfp1_phy_status = phy1;
      apply_cage_inputs(0, p0, phy0);
      apply_cage_inputs(1, p1, phy1);
      idle_cycles(6);
   endtask

   initial begin
      #(STIM_CYCLES * CLK_PERIOD * 2);
      $display("Watchdog expired before the tests finished");
      $display("Test failures found");
      $finish;
   end

   initial begin
      logic [7:0]  addr;
      logic [31:0] first;
      logic [31:0] second;
      int          k;
      sfp_pins_t   p0;
      sfp_pins_t   p1;
      void'($urandom(29167));
      total_errs        = 0;
      tests_run         = 0;
      tests_failed      = 0;
      i_rst_n           = 1'b0;
      i_req             = '{op: BUS_IDLE, addr: '0, data: '0};
      i_clock_status    = $urandom();
      i_sfp0_pins       = $urandom();
      i_sfp1_pins       = $urandom();
      i_sfp0_phy_status = $urandom();
      i_sfp1_phy_status = $urandom();
      exp_clk_status    = i_clock_status;
      exp_pins[0]       = i_sfp0_pins;
      exp_pins[1]       = i_sfp1_pins;
      exp_phy[0]        = i_sfp0_phy_status;
      exp_phy[1]        = i_sfp1_phy_status;
      reset_model();
      repeat (2) @(negedge clk);
      i_rst_n = 1'b1;

      begin_test("reset_values");
      idle_cycles(4);
      for (int i = 0; i < 7; i++) begin
         read_and_check(rb_addrs[i]);
      end
      check_value(96'(exp_set), 96'(o_settings));
      end_test();

      begin_test("random_writes");
      for (int i = 0; i < N_WRITES; i++) begin
         addr = ($urandom_range(0, 3) == 0) ? 8'($urandom()) : wr_addrs[$urandom_range(0, 7)];
         issue_write(addr, $urandom());
         // Address 0 is the counter, so unmapped picks start at 1
         addr = ($urandom_range(0, 3) == 0) ? 8'($urandom_range(1, 255)) :
                                              rb_addrs[$urandom_range(0, 6)];
         read_and_check(addr);
         idle_cycles($urandom_range(0, 2));
      end
      end_test();

      begin_test("counter_spacing");
      for (int i = 0; i < N_COUNTER; i++) begin
         k = (i < 4) ? 1 : $urandom_range(1, K_MAX);
         issue_read(`BC_RB_COUNTER, first);
         idle_cycles(k - 1);
         issue_read(`BC_RB_COUNTER, second);
         check_value(96'(k), 96'(second - first));
      end
      end_test();

      begin_test("pin_activity");
      for (int i = 0; i < N_PINS; i++) begin
         change_cages($urandom(), $urandom());
         // Skipped reads let the flags pile up
         if ($urandom_range(0, 1) == 1) begin
            read_and_check(`BC_RB_SFPP_STATUS0);
         end
         if ($urandom_range(0, 1) == 1) begin
            read_and_check(`BC_RB_SFPP_STATUS1);
         end
      end
      end_test();

      begin_test("clear_on_read");
      for (int i = 0; i < N_CLEAR; i++) begin
         p0 = exp_pins[0] ^ 3'($urandom_range(1, 7));
         p1 = exp_pins[1] ^ 3'($urandom_range(1, 7));
         change_cages(p0, p1);
         read_and_check(`BC_RB_SFPP_STATUS0);
         read_and_check(`BC_RB_SFPP_STATUS0);
         read_and_check(`BC_RB_SFPP_STATUS1);
      end
      end_test();

      begin_test("fixed_words");
      for (int i = 0; i < N_FIXED; i++) begin
         i_clock_status = $urandom();
         exp_clk_status = i_clock_status;
         read_and_check(`BC_RB_CLK_STATUS);
         read_and_check(`BC_RB_COMPAT_NUM);
      end
      end_test();

      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
               total_errs);
      if (total_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- source/board_ctrl_top.sv
// Board control register block
// Host request port into the settings registers, two SFP+ cage
// monitors and the registered readback path

`timescale 1ns/10ps

module board_ctrl_top (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  bus_pkg::bus_req_t    i_req,
   input  logic [7:0]           i_clock_status,
   input  board_pkg::sfp_pins_t i_sfp0_pins,
   input  board_pkg::sfp_pins_t i_sfp1_pins,
   input  logic [15:0]          i_sfp0_phy_status,
   input  logic [15:0]          i_sfp1_phy_status,
   output bus_pkg::rb_rsp_t     o_rsp,
   output board_pkg::settings_t o_settings,
   output logic                 o_ref_freq_changed
);

   import board_pkg::*;

   sfp_status_t sfp0_status;
   sfp_status_t sfp1_status;
   logic        sfp0_clear;
   logic        sfp1_clear;

   // ------------------------------
   // Settings registers
   // ------------------------------
   setting_regs regs (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_req              (i_req),
      .o_settings         (o_settings),
      .o_ref_freq_changed (o_ref_freq_changed)
   );

   // ------------------------------
   // SFP+ cages
   // ------------------------------
   sfp_status_monitor sfp0_mon (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_pins       (i_sfp0_pins),
      .i_phy_status (i_sfp0_phy_status),
      .i_clear      (sfp0_clear),
      .o_status     (sfp0_status)
   );

   sfp_status_monitor sfp1_mon (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_pins       (i_sfp1_pins),
      .i_phy_status (i_sfp1_phy_status),
      .i_clear      (sfp1_clear),
      .o_status     (sfp1_status)
   );

   // Readback and clear-on-read decode
   readback_mux rb_mux (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_req          (i_req),
      .i_settings     (o_settings),
      .i_clock_status (i_clock_status),
      .i_sfp0_status  (sfp0_status),
      .i_sfp1_status  (sfp1_status),
      .o_rsp          (o_rsp),
      .o_sfp0_clear   (sfp0_clear),
      .o_sfp1_clear   (sfp1_clear)
   );

endmodule

//--- source/readback_mux.sv
// Readback multiplexer
// Free-running counter, registered readback word selection and the
// clear-on-read pulses for the SFP+ cage status flags

`timescale 1ns/10ps

`include "board_ctrl_settings.svh"

module readback_mux (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  bus_pkg::bus_req_t      i_req,
   input  board_pkg::settings_t   i_settings,
   input  logic [7:0]             i_clock_status,
   input  board_pkg::sfp_status_t i_sfp0_status,
   input  board_pkg::sfp_status_t i_sfp1_status,
   output bus_pkg::rb_rsp_t       o_rsp,
   output logic                   o_sfp0_clear,
   output logic                   o_sfp1_clear
);

   import bus_pkg::*;

   localparam int unsigned DATA_W = `BC_DATA_W;

   logic              rd_req;
   logic [DATA_W-1:0] counter_q;
   logic [DATA_W-1:0] rd_word;
   logic              rsp_valid_q;
   logic [DATA_W-1:0] rsp_data_q;

   assign rd_req = (i_req.op == BUS_READ);

   // ------------------------------
   // Free-running counter
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         counter_q <= '0;
      end else begin
         counter_q <= counter_q + 1'b1;
      end
   end

   // ------------------------------
   // Word select
   // ------------------------------
   always_comb begin
      case (i_req.addr)
         `BC_RB_COUNTER:      rd_word = counter_q;
         `BC_RB_CLK_STATUS:   rd_word = DATA_W'(i_clock_status);
         `BC_RB_COMPAT_NUM:   rd_word = `BC_COMPAT_NUM;
         `BC_RB_SFPP_STATUS0: rd_word = i_sfp0_status;
         `BC_RB_SFPP_STATUS1: rd_word = i_sfp1_status;
         `BC_RB_FP_GPIO_SRC:  rd_word = DATA_W'(i_settings.fp_gpio_src);
         `BC_RB_LEDS:         rd_word = DATA_W'(i_settings.leds);
         `BC_RB_SW_RST:       rd_word = DATA_W'(i_settings.sw_rst);
         `BC_RB_CLOCK_CTRL:   rd_word = DATA_W'(i_settings.clock_control);
         `BC_RB_DEVICE_ID:    rd_word = DATA_W'(i_settings.device_id);
         `BC_RB_REF_FREQ:     rd_word = i_settings.ref_freq;
         // Cage 1 in bits 3:2, cage 0 in bits 1:0
         `BC_RB_SFPP_CTRL: begin
            rd_word = DATA_W'({i_settings.sfpp_ctrl1, i_settings.sfpp_ctrl0});
         end
         default:             rd_word = '0;
      endcase
   end

   // ------------------------------
   // Registered response
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= rd_req;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req) begin
         rsp_data_q <= rd_word;
      end
   end

   assign o_rsp = '{valid: rsp_valid_q, data: rsp_data_q};

   // Flags are captured above at the same edge they clear
   assign o_sfp0_clear = rd_req && (i_req.addr == `BC_RB_SFPP_STATUS0);
   assign o_sfp1_clear = rd_req && (i_req.addr == `BC_RB_SFPP_STATUS1);

   a_rsp_after_read : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      rd_req |=> o_rsp.valid
   ) else $error("Read without a response on the next cycle");

   a_rsp_needs_read : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_rsp.valid |-> $past(rd_req)
   ) else $error("Response valid without a read one cycle earlier");

endmodule

//--- source/sfp_status_monitor.sv
// SFP+ cage status monitor
// Synchronizes the cage pins and PHY status, keeps sticky change
// flags per pin and builds the cage status readback word

`timescale 1ns/10ps

`include "board_ctrl_settings.svh"

module sfp_status_monitor (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  board_pkg::sfp_pins_t         i_pins,
   input  logic [`BC_PHY_STATUS_W-1:0]  i_phy_status,
   input  logic                         i_clear,
   output board_pkg::sfp_status_t       o_status
);

   import board_pkg::*;

   localparam int unsigned SYNC_W = $bits(sfp_pins_t) + `BC_PHY_STATUS_W;

   logic [SYNC_W-1:0]           sync_q [`BC_SYNC_STAGES];
   sfp_pins_t                   sync_pins;
   logic [`BC_PHY_STATUS_W-1:0] sync_phy;
   sfp_pins_t                   pins_q;
   logic [2:0]                  pins_diff;
   logic [2:0]                  chg_q;

   // ------------------------------
   // Input synchronizers
   // ------------------------------
   // Every bit is treated as asynchronous to clk
   always_ff @(posedge clk) begin
      sync_q[0] <= {i_pins, i_phy_status};
      for (int s = 1; s < `BC_SYNC_STAGES; s++) begin
         sync_q[s] <= sync_q[s-1];
      end
   end

   assign {sync_pins, sync_phy} = sync_q[`BC_SYNC_STAGES-1];

   // Previous pin values for edge detection
   always_ff @(posedge clk) begin
      pins_q <= sync_pins;
   end

   assign pins_diff = sync_pins ^ pins_q;

   // ------------------------------
   // Sticky change flags
   // ------------------------------
   // A clear from the readback side beats a new change
   always_ff @(posedge clk) begin
      if (!i_rst_n || i_clear) begin
         chg_q <= '0;
      end else begin
         for (int b = 0; b < 3; b++) begin
            if (pins_diff[b]) begin
               chg_q[b] <= 1'b1;
            end
         end
      end
   end

   always_comb begin
      o_status.phy_status = sync_phy;
      o_status.rsvd       = '0;
      o_status.changed    = chg_q;
      o_status.current    = sync_pins;
   end

   // A rising flag needs the synchronized pin to have moved one cycle earlier
   a_flag_needs_edge : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      (chg_q & ~$past(chg_q) & ~($past(sync_pins) ^ $past(sync_pins, 2))) == '0
   ) else $error("SFP change flag rose without a pin edge");

endmodule

//--- source/setting_regs.sv
// Settings registers
// Decodes host writes against the settings map and holds every
// board-control register, with a pulse when the reference frequency is written

`timescale 1ns/10ps

`include "board_ctrl_settings.svh"

module setting_regs (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  bus_pkg::bus_req_t    i_req,
   output board_pkg::settings_t o_settings,
   output logic                 o_ref_freq_changed
);

   import bus_pkg::*;

   logic wr_en;
   logic ref_wr;

   assign wr_en  = (i_req.op == BUS_WRITE);
   assign ref_wr = wr_en && (i_req.addr == `BC_SR_REF_FREQ);

   // ------------------------------
   // Register storage
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_settings.leds          <= '0;
         o_settings.sw_rst        <= '0;
         o_settings.clock_control <= `BC_CLOCK_CTRL_RST;
         o_settings.device_id     <= '0;
         o_settings.ref_freq      <= `BC_REF_FREQ_RST;
         o_settings.sfpp_ctrl0    <= '0;
         o_settings.sfpp_ctrl1    <= '0;
         o_settings.fp_gpio_src   <= '0;
      end else if (wr_en) begin
         case (i_req.addr)
            `BC_SR_LEDS: begin
               o_settings.leds <= i_req.data[1:0];
            end
            // PHY, radio domain, radio PLL and IDELAYCTRL resets
            `BC_SR_SW_RST: begin
               o_settings.sw_rst <= i_req.data[3:0];
            end
            `BC_SR_CLOCK_CTRL: begin
               o_settings.clock_control <= i_req.data[7:0];
            end
            `BC_SR_DEVICE_ID: begin
               o_settings.device_id <= i_req.data[15:0];
            end
            `BC_SR_REF_FREQ: begin
               o_settings.ref_freq <= i_req.data;
            end
            // A set rate-select bit pulls the pad low
            `BC_SR_SFPP_CTRL0: begin
               o_settings.sfpp_ctrl0 <= i_req.data[1:0];
            end
            `BC_SR_SFPP_CTRL1: begin
               o_settings.sfpp_ctrl1 <= i_req.data[1:0];
            end
            // Two bits per front-panel pin
            `BC_SR_FP_GPIO_SRC: begin
               o_settings.fp_gpio_src <= i_req.data[23:0];
            end
            default: begin
            end
         endcase
      end
   end

   // ------------------------------
   // Reference change pulse
   // ------------------------------
   // High for the one cycle after the write edge
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_ref_freq_changed <= 1'b0;
      end else begin
         o_ref_freq_changed <= ref_wr;
      end
   end

   // Every pulse cycle follows a write that loaded the register
   a_ref_pulse_per_write : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_ref_freq_changed |-> (o_settings.ref_freq == $past(i_req.data))
   ) else $error("ref_freq_changed without a matching reference frequency write");

endmodule

//--- source/board_pkg.sv
// Board-side types
// SFP+ cage pins, the cage status readback word and the settings bundle

`include "board_ctrl_settings.svh"

package board_pkg;

   // Low-speed SFP+ cage pins
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   // ------------------------------
   // Cage status readback word
   // ------------------------------
   typedef struct packed {
      logic [`BC_PHY_STATUS_W-1:0] phy_status;
      logic [9:0]                  rsvd;
      sfp_pins_t                   changed;
      sfp_pins_t                   current;
   } sfp_status_t;

   // ------------------------------
   // Settings register bundle
   // ------------------------------
   typedef struct packed {
      logic [1:0]  leds;
      logic [3:0]  sw_rst;
      logic [7:0]  clock_control;
      logic [15:0] device_id;
      logic [31:0] ref_freq;
      logic [1:0]  sfpp_ctrl0;
      logic [1:0]  sfpp_ctrl1;
      logic [23:0] fp_gpio_src;
   } settings_t;

endpackage

//--- source/bus_pkg.sv
// Host bus types
// Request opcode, request word and the registered readback response

`include "board_ctrl_settings.svh"

package bus_pkg;

   // ------------------------------
   // Request opcode
   // ------------------------------
   typedef enum logic [1:0] {
      BUS_IDLE  = 2'd0,
      BUS_WRITE = 2'd1,
      BUS_READ  = 2'd2
   } bus_op_e;

   // ------------------------------
   // Request from the host
   // ------------------------------
   // One request per cycle at most, no ready
   typedef struct packed {
      bus_op_e                 op;
      logic [`BC_ADDR_W-1:0]   addr;
      logic [`BC_DATA_W-1:0]   data;
   } bus_req_t;

   // ------------------------------
   // Readback response
   // ------------------------------
   // Valid for one cycle, the cycle after the read
   typedef struct packed {
      logic                    valid;
      logic [`BC_DATA_W-1:0]   data;
   } rb_rsp_t;

endpackage

//--- source/board_ctrl_settings.svh
// Board control register block settings
// Address map of the settings and readback buses, reset values
// and the compatibility number reported to the host

`ifndef BOARD_CTRL_SETTINGS_SVH
`define BOARD_CTRL_SETTINGS_SVH

// Bus widths
`define BC_ADDR_W          8
`define BC_DATA_W          32
`define BC_PHY_STATUS_W    16
`define BC_SYNC_STAGES     2

// ------------------------------
// Settings register addresses
// ------------------------------
`define BC_SR_LEDS         8'd0
`define BC_SR_SW_RST       8'd1
`define BC_SR_CLOCK_CTRL   8'd2
`define BC_SR_DEVICE_ID    8'd3
`define BC_SR_REF_FREQ     8'd4
`define BC_SR_SFPP_CTRL0   8'd8
`define BC_SR_SFPP_CTRL1   8'd9
`define BC_SR_FP_GPIO_SRC  8'd72

// ------------------------------
// Readback addresses
// ------------------------------
`define BC_RB_COUNTER      8'd0
`define BC_RB_CLK_STATUS   8'd3
`define BC_RB_COMPAT_NUM   8'd6
`define BC_RB_SFPP_STATUS0 8'd8
`define BC_RB_SFPP_STATUS1 8'd9
`define BC_RB_FP_GPIO_SRC  8'd13
`define BC_RB_LEDS         8'd16
`define BC_RB_SW_RST       8'd17
`define BC_RB_CLOCK_CTRL   8'd18
`define BC_RB_DEVICE_ID    8'd19
`define BC_RB_REF_FREQ     8'd20
`define BC_RB_SFPP_CTRL    8'd24

// Bit 6 turns the GPS-disciplined oscillator on
`define BC_CLOCK_CTRL_RST  8'h40
// 10 MHz reference
`define BC_REF_FREQ_RST    32'd10_000_000

// Major in the upper half, minor in the lower half
`define BC_COMPAT_MAJOR    16'h0027
`define BC_COMPAT_MINOR    16'h0000
`define BC_COMPAT_NUM      {`BC_COMPAT_MAJOR, `BC_COMPAT_MINOR}

`endif
